//--- mfp_pkg.sv
/*
 * mfp shared definitions
 * register map, timer mode codes, prescaler divisors, serial FIFO size,
 * interrupt source numbering and the 16-bit interrupt register word
 */
`default_nettype none

package mfp_pkg;

	// cpu register map, 5-bit word address
	localparam logic [4:0] ADDR_GPIP = 5'h00;
	localparam logic [4:0] ADDR_AER  = 5'h01;
	localparam logic [4:0] ADDR_DDR  = 5'h02;
	localparam logic [4:0] ADDR_IERA = 5'h03;
	localparam logic [4:0] ADDR_IERB = 5'h04;
	localparam logic [4:0] ADDR_IPRA = 5'h05;
	localparam logic [4:0] ADDR_IPRB = 5'h06;
	localparam logic [4:0] ADDR_ISRA = 5'h07;
	localparam logic [4:0] ADDR_ISRB = 5'h08;
	localparam logic [4:0] ADDR_IMRA = 5'h09;
	localparam logic [4:0] ADDR_IMRB = 5'h0a;
	localparam logic [4:0] ADDR_VR   = 5'h0b;
	localparam logic [4:0] ADDR_TACR = 5'h0c;
	localparam logic [4:0] ADDR_TBCR = 5'h0d;
	localparam logic [4:0] ADDR_TADR = 5'h0f;
	localparam logic [4:0] ADDR_TBDR = 5'h10;
	localparam logic [4:0] ADDR_RSR  = 5'h15;
	localparam logic [4:0] ADDR_TSR  = 5'h16;
	localparam logic [4:0] ADDR_UDR  = 5'h17;

	// timer control field, codes 1..7 are delay mode
	localparam logic [3:0] TMODE_STOP  = 4'd0;
	localparam logic [3:0] TMODE_EVENT = 4'd8;

	// xclk ticks per count step, indexed by the delay code
	// entry 0 belongs to the stopped timer and is never selected
	localparam logic [7:0] PRESCALE_DIV [0:7] = '{
		8'd0, 8'd4, 8'd10, 8'd16, 8'd50, 8'd64, 8'd100, 8'd200
	};

	// serial fifo size
	localparam int FIFO_DEPTH = 4;
	localparam int FIFO_AW    = 2;

	// interrupt source bit numbers, 15 wins
	localparam int IRQ_GPIO7    = 15;
	localparam int IRQ_GPIO6    = 14;
	localparam int IRQ_TIMER_A  = 13;
	localparam int IRQ_RX_FULL  = 12;
	localparam int IRQ_RX_ERR   = 11;
	localparam int IRQ_TX_EMPTY = 10;
	localparam int IRQ_TX_ERR   = 9;
	localparam int IRQ_TIMER_B  = 8;
	localparam int IRQ_GPIO5    = 7;
	localparam int IRQ_GPIO4    = 6;
	localparam int IRQ_TIMER_C  = 5;
	localparam int IRQ_TIMER_D  = 4;
	// gpio 3..0 sit on source bits 3..0
	localparam int IRQ_GPIO_LO  = 0;

	// one interrupt register, seen whole or as bank a (high) and bank b (low)
	typedef union packed {
		logic [15:0] word;
		struct packed {
			logic [7:0] a;
			logic [7:0] b;
		} bank;
	} irq_word_u;

endpackage

`default_nettype wire

//--- mfp_fifo.sv
/*
 * serial byte fifo
 * circular buffer with occupancy count
 * a push shows at the output one cycle later
 * overflow is dropped and an empty pop ignored
 */
`timescale 1ns/1ns
`default_nettype none

module mfp_fifo (
	input  wire       iack,
	input  wire       reset,
	input  wire       push_i,
	input  wire [7:0] push_data_i,
	input  wire       pop_i,
	output wire [7:0] pop_data_o,
	output wire       avail_o,
	output wire       full_o
);
	import mfp_pkg::*;

	logic [7:0]         mem [FIFO_DEPTH];
	logic [FIFO_AW-1:0] wr_ptr;
	logic [FIFO_AW-1:0] rd_ptr;
	logic [FIFO_AW:0]   count;
	logic               do_push;
	logic               do_pop;

	assign full_o  = (count == FIFO_DEPTH[FIFO_AW:0]);
	assign avail_o = (count != '0);
	// oldest entry always visible
	assign pop_data_o = mem[rd_ptr];

	assign do_push = push_i & ~full_o;
	assign do_pop  = pop_i & avail_o;

	// entry storage
	always_ff @(posedge iack) begin
		if (do_push)
			mem[wr_ptr] <= push_data_i;
	end

	always_ff @(posedge iack) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + {{FIFO_AW{1'b0}}, do_push} - {{FIFO_AW{1'b0}}, do_pop};
		end
	end

	// a byte lost to overflow is worth flagging
	a_no_overflow: assert property (@(posedge iack) disable iff (reset)
		!(push_i && full_o && !pop_i));

endmodule

`default_nettype wire

//--- mfp_timer.sv
/*
 * mfp timer (a or b)
 * delay mode counts prescaled xclk ticks, event mode counts rising
 * edges of the event input; on expiry it reloads and pulses done
 */
`timescale 1ns/1ns
`default_nettype none

module mfp_timer (
	input  wire       iack,
	input  wire       reset,
	input  wire       ctrl_we_i,
	input  wire       dat_we_i,
	input  wire [7:0] din_i,
	input  wire       xclk_en_i,
	input  wire       event_i,
	output wire [3:0] ctrl_o,
	output wire [7:0] count_o,
	output logic      done_o
);
	import mfp_pkg::*;

	logic [3:0] ctrl_q;
	logic [7:0] reload_q;
	logic [7:0] count_q;
	logic [7:0] presc_q;
	logic       event_q;
	logic [7:0] div;
	logic       delay_mode;
	logic       event_mode;
	logic       presc_wrap;
	logic       tick;

	assign ctrl_o  = ctrl_q;
	assign count_o = count_q;

	// pulse width codes 9..15 are treated as stopped
	assign delay_mode = (ctrl_q != TMODE_STOP) && !ctrl_q[3];
	assign event_mode = (ctrl_q == TMODE_EVENT);

	assign div        = PRESCALE_DIV[ctrl_q[2:0]];
	assign presc_wrap = (presc_q == div - 8'd1);

	// one count step, either prescaler rollover or event rising edge
	assign tick = (delay_mode && xclk_en_i && presc_wrap) ||
		(event_mode && event_i && !event_q);

	always_ff @(posedge iack) begin
		if (reset) begin
			ctrl_q   <= TMODE_STOP;
			reload_q <= '0;
			count_q  <= '0;
			presc_q  <= '0;
			event_q  <= 1'b0;
			done_o   <= 1'b0;
		end else begin
			event_q <= event_i;
			done_o  <= 1'b0;

			// new mode restarts the prescaler
			if (ctrl_we_i) begin
				ctrl_q  <= din_i[3:0];
				presc_q <= '0;
			end else if (delay_mode && xclk_en_i) begin
				presc_q <= presc_wrap ? 8'd0 : presc_q + 8'd1;
			end

			// data write loads both reload value and counter
			if (dat_we_i) begin
				reload_q <= din_i;
				count_q  <= din_i;
			end else if (tick) begin
				if (count_q == 8'd1) begin
					count_q <= reload_q;
					done_o  <= 1'b1;
				end else begin
					// 0 wraps to 255, so reload 0 gives 256 steps
					count_q <= count_q - 8'd1;
				end
			end
		end
	end

	// prescaler of 4 or more and edge detect keep done a single pulse
	a_done_pulse: assert property (@(posedge iack) disable iff (reset)
		done_o |=> !done_o);

endmodule

`default_nettype wire

//--- mfp_irq_ctrl.sv
/*
 * mfp interrupt controller
 * ier/ipr/isr/imr/vr registers, priority search over 16 sources,
 * irq request and vectored acknowledge with optional in-service set
 */
`timescale 1ns/1ns
`default_nettype none

module mfp_irq_ctrl (
	input  wire                iack,
	input  wire                reset,
	input  wire                reg_we_i,
	input  wire [4:0]          reg_addr_i,
	input  wire [7:0]          reg_din_i,
	input  wire                int_ack_i,
	input  wire [15:0]         src_i,
	output mfp_pkg::irq_word_u ier_o,
	output mfp_pkg::irq_word_u ipr_o,
	output mfp_pkg::irq_word_u isr_o,
	output mfp_pkg::irq_word_u imr_o,
	output wire [7:0]          vr_o,
	output wire [7:0]          vector_o,
	output wire                irq_o
);
	import mfp_pkg::*;

	irq_word_u   ier_q, ipr_q, isr_q, imr_q;
	irq_word_u   ier_n, ipr_n, isr_n, imr_n;
	logic [7:0]  vr_q, vr_n;
	logic [15:0] pend;
	logic [3:0]  pend_num;
	logic [3:0]  isr_num;
	logic        pend_any;
	logic        isr_any;

	// number of the highest set bit, 0 when none
	function automatic logic [3:0] top_bit(input logic [15:0] v);
		logic [3:0] n;
		n = 4'd0;
		for (int i = 0; i < 16; i++) begin
			if (v[i])
				n = 4'(i);
		end
		return n;
	endfunction

	assign pend     = ipr_q.word & imr_q.word;
	assign pend_any = |pend;
	assign isr_any  = |isr_q.word;
	assign pend_num = top_bit(pend);
	assign isr_num  = top_bit(isr_q.word);

	// only a source above the one in service may interrupt
	assign irq_o    = pend_any && (!isr_any || (pend_num > isr_num));
	assign vector_o = {vr_q[7:4], pend_num};

	assign ier_o = ier_q;
	assign ipr_o = ipr_q;
	assign isr_o = isr_q;
	assign imr_o = imr_q;
	assign vr_o  = vr_q;

	always_comb begin
		ier_n = ier_q;
		ipr_n = ipr_q;
		isr_n = isr_q;
		imr_n = imr_q;
		vr_n  = vr_q;

		// acknowledge moves the winner out of pending
		// and, in software eoi mode, into service
		if (int_ack_i && pend_any) begin
			ipr_n.word[pend_num] = 1'b0;
			if (vr_q[3])
				isr_n.word[pend_num] = 1'b1;
		end

		if (reg_we_i) begin
			case (reg_addr_i)
				// disabling a source also drops its pending bit
				ADDR_IERA: begin
					ier_n.bank.a = reg_din_i;
					ipr_n.bank.a = ipr_n.bank.a & reg_din_i;
				end
				ADDR_IERB: begin
					ier_n.bank.b = reg_din_i;
					ipr_n.bank.b = ipr_n.bank.b & reg_din_i;
				end
				// pending and in-service clear where a 0 is written
				ADDR_IPRA: ipr_n.bank.a = ipr_n.bank.a & reg_din_i;
				ADDR_IPRB: ipr_n.bank.b = ipr_n.bank.b & reg_din_i;
				ADDR_ISRA: isr_n.bank.a = isr_n.bank.a & reg_din_i;
				ADDR_ISRB: isr_n.bank.b = isr_n.bank.b & reg_din_i;
				ADDR_IMRA: imr_n.bank.a = reg_din_i;
				ADDR_IMRB: imr_n.bank.b = reg_din_i;
				ADDR_VR:   vr_n = reg_din_i;
				default: ;
			endcase
		end

		// new events latch through the updated enables
		ipr_n.word = ipr_n.word | (src_i & ier_n.word);
	end

	always_ff @(posedge iack) begin
		if (reset) begin
			ier_q <= '0;
			ipr_q <= '0;
			isr_q <= '0;
			imr_q <= '0;
			vr_q  <= '0;
		end else begin
			ier_q <= ier_n;
			ipr_q <= ipr_n;
			isr_q <= isr_n;
			imr_q <= imr_n;
			vr_q  <= vr_n;
		end
	end

	a_ipr_enabled: assert property (@(posedge iack) disable iff (reset)
		(ipr_q.word & ~ier_q.word) == 16'h0000);

endmodule

`default_nettype wire

//--- mfp_regs.sv
/*
 * mfp cpu register front end
 * bus decode into write strobes, gpio registers and edge detect,
 * serial control bits and the read data / vector multiplexer
 */
`timescale 1ns/1ns
`default_nettype none

module mfp_regs (
	input  wire                iack,
	input  wire                reset,
	input  wire                sel_i,
	input  wire                ds_i,
	input  wire                rw_i,
	input  wire [4:0]          addr_i,
	input  wire [7:0]          din_i,
	input  wire                int_ack_i,
	input  wire [7:0]          gpio_i,
	input  wire [1:0]          t_i,
	input  mfp_pkg::irq_word_u ier_i,
	input  mfp_pkg::irq_word_u ipr_i,
	input  mfp_pkg::irq_word_u isr_i,
	input  mfp_pkg::irq_word_u imr_i,
	input  wire [7:0]          vr_i,
	input  wire [7:0]          vector_i,
	input  wire [3:0]          ta_ctrl_i,
	input  wire [7:0]          ta_count_i,
	input  wire [3:0]          tb_ctrl_i,
	input  wire [7:0]          tb_count_i,
	input  wire [7:0]          rx_data_i,
	input  wire                rx_avail_i,
	input  wire                tx_full_i,
	output logic [7:0]         dout_o,
	output wire                reg_we_o,
	output wire                ta_ctrl_we_o,
	output wire                ta_dat_we_o,
	output wire                tb_ctrl_we_o,
	output wire                tb_dat_we_o,
	output wire                tx_push_o,
	output wire                rx_pop_o,
	output wire                ta_event_o,
	output wire                tb_event_o,
	output wire [7:0]          gpio_src_o
);
	import mfp_pkg::*;

	logic [7:0] gpip_q, aer_q, ddr_q;
	logic [1:0] rx_ctrl_q;
	logic [3:0] tx_ctrl_q;
	logic       wr, rd;
	logic       rd_udr, rd_udr_q;
	logic [7:0] gpio_eff, lvl, lvl_q;

	assign wr = sel_i & ~ds_i & ~rw_i;
	assign rd = sel_i & ~ds_i & rw_i;

	// interrupt registers span iera..vr
	assign reg_we_o     = wr && (addr_i >= ADDR_IERA) && (addr_i <= ADDR_VR);
	assign ta_ctrl_we_o = wr && (addr_i == ADDR_TACR);
	assign tb_ctrl_we_o = wr && (addr_i == ADDR_TBCR);
	assign ta_dat_we_o  = wr && (addr_i == ADDR_TADR);
	assign tb_dat_we_o  = wr && (addr_i == ADDR_TBDR);
	assign tx_push_o    = wr && (addr_i == ADDR_UDR);

	// one pop per udr read cycle even if ds stays low for several clocks
	assign rd_udr   = rd && (addr_i == ADDR_UDR);
	assign rx_pop_o = rd_udr & ~rd_udr_q;

	// timer inputs take the aer polarity so aer 1 counts rising edges
	assign ta_event_o = t_i[0] ~^ aer_q[4];
	assign tb_event_o = t_i[1] ~^ aer_q[3];

	// gpio 4/3 interrupts follow the timer inputs in event mode
	always_comb begin
		gpio_eff = gpio_i;
		if (ta_ctrl_i == TMODE_EVENT)
			gpio_eff[4] = t_i[0];
		if (tb_ctrl_i == TMODE_EVENT)
			gpio_eff[3] = t_i[1];
	end

	assign lvl        = ~(gpio_eff ^ aer_q);
	assign gpio_src_o = lvl & ~lvl_q;

	// previous active levels for the gpio edge detect
	always_ff @(posedge iack) begin
		lvl_q <= lvl;
	end

	always_ff @(posedge iack) begin
		if (reset) begin
			gpip_q    <= '0;
			aer_q     <= '0;
			ddr_q     <= '0;
			rx_ctrl_q <= '0;
			tx_ctrl_q <= '0;
			rd_udr_q  <= 1'b0;
		end else begin
			rd_udr_q <= rd_udr;
			if (wr) begin
				case (addr_i)
					ADDR_GPIP: gpip_q    <= din_i;
					ADDR_AER:  aer_q     <= din_i;
					ADDR_DDR:  ddr_q     <= din_i;
					ADDR_RSR:  rx_ctrl_q <= din_i[1:0];
					ADDR_TSR:  tx_ctrl_q <= din_i[3:0];
					default: ;
				endcase
			end
		end
	end

	// register read wins over the acknowledge vector
	always_comb begin
		dout_o = 8'h00;
		if (rd) begin
			case (addr_i)
				// ddr 1 bits read back the output latch
				ADDR_GPIP: dout_o = (gpio_i & ~ddr_q) | (gpip_q & ddr_q);
				ADDR_AER:  dout_o = aer_q;
				ADDR_DDR:  dout_o = ddr_q;
				ADDR_IERA: dout_o = ier_i.bank.a;
				ADDR_IERB: dout_o = ier_i.bank.b;
				ADDR_IPRA: dout_o = ipr_i.bank.a;
				ADDR_IPRB: dout_o = ipr_i.bank.b;
				ADDR_ISRA: dout_o = isr_i.bank.a;
				ADDR_ISRB: dout_o = isr_i.bank.b;
				ADDR_IMRA: dout_o = imr_i.bank.a;
				ADDR_IMRB: dout_o = imr_i.bank.b;
				ADDR_VR:   dout_o = vr_i;
				ADDR_TACR: dout_o = {4'h0, ta_ctrl_i};
				ADDR_TBCR: dout_o = {4'h0, tb_ctrl_i};
				ADDR_TADR: dout_o = ta_count_i;
				ADDR_TBDR: dout_o = tb_count_i;
				ADDR_RSR:  dout_o = {rx_avail_i, 5'b00000, rx_ctrl_q};
				// buffer empty reported while the tx fifo has room
				ADDR_TSR:  dout_o = {~tx_full_i, 3'b000, tx_ctrl_q};
				ADDR_UDR:  dout_o = rx_data_i;
				default:   dout_o = 8'h00;
			endcase
		end else if (int_ack_i) begin
			dout_o = vector_i;
		end
	end

endmodule

`default_nettype wire

//--- mfp_top.sv
/*
 * mfp top level
 * register front end, timers a and b, interrupt controller
 * and the two serial fifos
 */
`timescale 1ns/1ns
`default_nettype none

module mfp_top (
	input  wire       iack,
	input  wire       reset,
	input  wire       sel_i,
	input  wire       ds_i,
	input  wire       rw_i,
	input  wire [4:0] addr_i,
	input  wire [7:0] din_i,
	output wire [7:0] dout_o,
	output wire       irq_o,
	input  wire       int_ack_i,
	input  wire [7:0] gpio_i,
	input  wire [1:0] t_i,
	input  wire       xclk_en_i,
	output wire [7:0] ser_out_data_o,
	output wire       ser_out_avail_o,
	input  wire       ser_out_strobe_i,
	input  wire [7:0] ser_in_data_i,
	input  wire       ser_in_strobe_i,
	output wire       ser_in_full_o
);
	import mfp_pkg::*;

	irq_word_u   ier, ipr, isr, imr;
	wire [7:0]   vr, vector;
	wire         reg_we;
	wire         ta_ctrl_we, ta_dat_we, tb_ctrl_we, tb_dat_we;
	wire [3:0]   ta_ctrl, tb_ctrl;
	wire [7:0]   ta_count, tb_count;
	wire         ta_done, tb_done, ta_event, tb_event;
	wire         tx_push, tx_full, rx_pop, rx_avail;
	wire [7:0]   rx_data;
	wire [7:0]   gpio_src;
	wire [15:0]  src;

	// interrupt sources in priority order
	assign src[IRQ_GPIO7]    = gpio_src[7];
	assign src[IRQ_GPIO6]    = gpio_src[6];
	assign src[IRQ_TIMER_A]  = ta_done;
	assign src[IRQ_RX_FULL]  = rx_avail;
	assign src[IRQ_RX_ERR]   = 1'b0;
	assign src[IRQ_TX_EMPTY] = ~tx_full;
	assign src[IRQ_TX_ERR]   = 1'b0;
	assign src[IRQ_TIMER_B]  = tb_done;
	assign src[IRQ_GPIO5]    = gpio_src[5];
	assign src[IRQ_GPIO4]    = gpio_src[4];
	// timers c and d are not built
	assign src[IRQ_TIMER_C]  = 1'b0;
	assign src[IRQ_TIMER_D]  = 1'b0;
	assign src[IRQ_GPIO_LO +: 4] = gpio_src[3:0];

	mfp_regs u_regs (
		.iack(iack), .reset(reset), .sel_i(sel_i), .ds_i(ds_i), .rw_i(rw_i),
		.addr_i(addr_i), .din_i(din_i), .int_ack_i(int_ack_i), .gpio_i(gpio_i),
		.t_i(t_i), .ier_i(ier), .ipr_i(ipr), .isr_i(isr), .imr_i(imr), .vr_i(vr),
		.vector_i(vector), .ta_ctrl_i(ta_ctrl), .ta_count_i(ta_count),
		.tb_ctrl_i(tb_ctrl), .tb_count_i(tb_count), .rx_data_i(rx_data),
		.rx_avail_i(rx_avail), .tx_full_i(tx_full), .dout_o(dout_o),
		.reg_we_o(reg_we), .ta_ctrl_we_o(ta_ctrl_we), .ta_dat_we_o(ta_dat_we),
		.tb_ctrl_we_o(tb_ctrl_we), .tb_dat_we_o(tb_dat_we), .tx_push_o(tx_push),
		.rx_pop_o(rx_pop), .ta_event_o(ta_event), .tb_event_o(tb_event),
		.gpio_src_o(gpio_src)
	);

	mfp_irq_ctrl u_irq_ctrl (
		.iack(iack), .reset(reset), .reg_we_i(reg_we), .reg_addr_i(addr_i),
		.reg_din_i(din_i), .int_ack_i(int_ack_i), .src_i(src), .ier_o(ier),
		.ipr_o(ipr), .isr_o(isr), .imr_o(imr), .vr_o(vr), .vector_o(vector),
		.irq_o(irq_o)
	);

	mfp_timer u_timer_a (
		.iack(iack), .reset(reset), .ctrl_we_i(ta_ctrl_we), .dat_we_i(ta_dat_we),
		.din_i(din_i), .xclk_en_i(xclk_en_i), .event_i(ta_event),
		.ctrl_o(ta_ctrl), .count_o(ta_count), .done_o(ta_done)
	);

	mfp_timer u_timer_b (
		.iack(iack), .reset(reset), .ctrl_we_i(tb_ctrl_we), .dat_we_i(tb_dat_we),
		.din_i(din_i), .xclk_en_i(xclk_en_i), .event_i(tb_event),
		.ctrl_o(tb_ctrl), .count_o(tb_count), .done_o(tb_done)
	);

	// cpu fills, outside controller drains by strobe
	mfp_fifo u_tx_fifo (
		.iack(iack), .reset(reset), .push_i(tx_push), .push_data_i(din_i),
		.pop_i(ser_out_strobe_i), .pop_data_o(ser_out_data_o),
		.avail_o(ser_out_avail_o), .full_o(tx_full)
	);

	// outside controller fills, cpu drains through udr reads
	mfp_fifo u_rx_fifo (
		.iack(iack), .reset(reset), .push_i(ser_in_strobe_i),
		.push_data_i(ser_in_data_i), .pop_i(rx_pop), .pop_data_o(rx_data),
		.avail_o(rx_avail), .full_o(ser_in_full_o)
	);

endmodule

`default_nettype wire

//--- tb_mfp.sv
/*
 * testbench for the mfp top level
 * every cpu read is checked against a register shadow model
 * tests cover gpio, interrupts and priority, timer a and the serial fifos
 */
`timescale 1ns/1ns
`default_nettype none

module tb_mfp;
	import mfp_pkg::*;

	// well above the length of the full run
	localparam int CYCLE_LIMIT = 20000;

	logic        iack = 1'b0;
	logic        reset;
	logic        sel_i;
	logic        ds_i;
	logic        rw_i;
	logic [4:0]  addr_i;
	logic [7:0]  din_i;
	logic        int_ack_i;
	logic [7:0]  gpio_i;
	logic [1:0]  t_i;
	logic        xclk_en_i;
	logic        ser_out_strobe_i;
	logic [7:0]  ser_in_data_i;
	logic        ser_in_strobe_i;
	wire  [7:0]  dout_o;
	wire         irq_o;
	wire  [7:0]  ser_out_data_o;
	wire         ser_out_avail_o;
	wire         ser_in_full_o;

	// shadow copy of the register state
	logic [7:0]  sh_gpip, sh_aer, sh_ddr, sh_vr, sh_tadr, sh_tbdr;
	logic [3:0]  sh_tacr, sh_tbcr, sh_tsr;
	logic [1:0]  sh_rsr;
	irq_word_u   sh_ier, sh_ipr, sh_isr, sh_imr;
	logic [7:0]  tx_q[$];
	logic [7:0]  rx_q[$];
	logic [31:0] lcg_state = 32'h1bca_1daa;
	int          cycles = 0;

	mfp_top u_dut (
		.iack(iack), .reset(reset), .sel_i(sel_i), .ds_i(ds_i), .rw_i(rw_i),
		.addr_i(addr_i), .din_i(din_i), .dout_o(dout_o), .irq_o(irq_o),
		.int_ack_i(int_ack_i), .gpio_i(gpio_i), .t_i(t_i), .xclk_en_i(xclk_en_i),
		.ser_out_data_o(ser_out_data_o), .ser_out_avail_o(ser_out_avail_o),
		.ser_out_strobe_i(ser_out_strobe_i), .ser_in_data_i(ser_in_data_i),
		.ser_in_strobe_i(ser_in_strobe_i), .ser_in_full_o(ser_in_full_o)
	);

	always #50 iack = ~iack;

	always @(posedge iack) begin
		cycles <= cycles + 1;
		if (cycles == CYCLE_LIMIT) begin
			$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("test failed");
			$fatal(1);
		end
	end

	task automatic check_byte(input string name, input logic [7:0] exp,
		input logic [7:0] got);
		if (got !== exp) begin
			$display("ERROR %s expected %h actual %h", name, exp, got);
			$display("test failed");
			$fatal(1);
		end
	endtask

	task automatic check_word(input string name, input irq_word_u exp,
		input irq_word_u got);
		if (got.word !== exp.word) begin
			$display("ERROR %s expected %h actual %h", name, exp.word, got.word);
			$display("test failed");
			$fatal(1);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic got);
		if (got !== exp) begin
			$display("ERROR %s expected %h actual %h", name, exp, got);
			$display("test failed");
			$fatal(1);
		end
	endtask

	// lcg, byte taken from the middle of the state
	function automatic logic [7:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[23:16];
	endfunction

	// expected read data from the shadow registers
	function automatic logic [7:0] model_read(input logic [4:0] a);
		logic [7:0] v;
		case (a)
			ADDR_GPIP: v = (gpio_i & ~sh_ddr) | (sh_gpip & sh_ddr);
			ADDR_AER:  v = sh_aer;
			ADDR_DDR:  v = sh_ddr;
			ADDR_IERA: v = sh_ier.bank.a;
			ADDR_IERB: v = sh_ier.bank.b;
			ADDR_IPRA: v = sh_ipr.bank.a;
			ADDR_IPRB: v = sh_ipr.bank.b;
			ADDR_ISRA: v = sh_isr.bank.a;
			ADDR_ISRB: v = sh_isr.bank.b;
			ADDR_IMRA: v = sh_imr.bank.a;
			ADDR_IMRB: v = sh_imr.bank.b;
			ADDR_VR:   v = sh_vr;
			ADDR_TACR: v = {4'h0, sh_tacr};
			ADDR_TBCR: v = {4'h0, sh_tbcr};
			ADDR_TADR: v = sh_tadr;
			ADDR_TBDR: v = sh_tbdr;
			ADDR_RSR:  v = {rx_q.size() != 0, 5'b00000, sh_rsr};
			// bit 7 set while the transmit fifo has room
			ADDR_TSR:  v = {tx_q.size() != FIFO_DEPTH, 3'b000, sh_tsr};
			ADDR_UDR:  v = (rx_q.size() != 0) ? rx_q[0] : 8'h00;
			default:   v = 8'h00;
		endcase
		return v;
	endfunction

	// register write rules applied to the shadow
	function automatic void shadow_write(input logic [4:0] a, input logic [7:0] d);
		case (a)
			ADDR_GPIP: sh_gpip = d;
			ADDR_AER:  sh_aer = d;
			ADDR_DDR:  sh_ddr = d;
			ADDR_IERA: begin
				sh_ier.bank.a = d;
				sh_ipr.bank.a = sh_ipr.bank.a & d;
			end
			ADDR_IERB: begin
				sh_ier.bank.b = d;
				sh_ipr.bank.b = sh_ipr.bank.b & d;
			end
			ADDR_IPRA: sh_ipr.bank.a = sh_ipr.bank.a & d;
			ADDR_IPRB: sh_ipr.bank.b = sh_ipr.bank.b & d;
			ADDR_ISRA: sh_isr.bank.a = sh_isr.bank.a & d;
			ADDR_ISRB: sh_isr.bank.b = sh_isr.bank.b & d;
			ADDR_IMRA: sh_imr.bank.a = d;
			ADDR_IMRB: sh_imr.bank.b = d;
			ADDR_VR:   sh_vr = d;
			ADDR_TACR: sh_tacr = d[3:0];
			ADDR_TBCR: sh_tbcr = d[3:0];
			ADDR_TADR: sh_tadr = d;
			ADDR_TBDR: sh_tbdr = d;
			ADDR_RSR:  sh_rsr = d[1:0];
			ADDR_TSR:  sh_tsr = d[3:0];
			ADDR_UDR: begin
				if (tx_q.size() < FIFO_DEPTH)
					tx_q.push_back(d);
			end
			default: ;
		endcase
	endfunction

	// every cpu read compared against the model at the falling edge
	always @(negedge iack) begin
		if (!reset && sel_i && !ds_i && rw_i)
			check_byte("dout_o", model_read(addr_i), dout_o);
	end

	// one write cycle, the write lands on the second edge
	task automatic bus_write(input logic [4:0] a, input logic [7:0] d);
		@(posedge iack);
		sel_i  <= 1'b1;
		ds_i   <= 1'b0;
		rw_i   <= 1'b0;
		addr_i <= a;
		din_i  <= d;
		@(posedge iack);
		sel_i <= 1'b0;
		ds_i  <= 1'b1;
		rw_i  <= 1'b1;
		shadow_write(a, d);
	endtask

	// one read cycle, a udr read pops on its closing edge
	task automatic bus_read(input logic [4:0] a, output logic [7:0] d);
		@(posedge iack);
		sel_i  <= 1'b1;
		ds_i   <= 1'b0;
		rw_i   <= 1'b1;
		addr_i <= a;
		@(negedge iack);
		d = dout_o;
		@(posedge iack);
		sel_i <= 1'b0;
		ds_i  <= 1'b1;
		if (a == ADDR_UDR && rx_q.size() != 0)
			void'(rx_q.pop_front());
	endtask

	// bank a then bank b, reassembled as one word
	task automatic check_irq_reg(input string name, input logic [4:0] addr_a,
		input irq_word_u exp);
		irq_word_u  got;
		logic [7:0] hi;
		logic [7:0] lo;
		bus_read(addr_a, hi);
		bus_read(addr_a + 5'd1, lo);
		got.bank.a = hi;
		got.bank.b = lo;
		check_word(name, exp, got);
	endtask

	task automatic expect_irq(input logic e);
		@(negedge iack);
		check_bit("irq_o", e, irq_o);
	endtask

	// pin change, pending bit lands on the following edge
	task automatic drive_gpio(input int idx, input logic v);
		@(posedge iack);
		gpio_i[idx] <= v;
		@(posedge iack);
	endtask

	task automatic int_acknowledge(input logic [3:0] num);
		@(posedge iack);
		int_ack_i <= 1'b1;
		@(negedge iack);
		check_byte("dout_o", {sh_vr[7:4], num}, dout_o);
		@(posedge iack);
		int_ack_i <= 1'b0;
		sh_ipr.word[num] = 1'b0;
		// software end of interrupt mode
		if (sh_vr[3])
			sh_isr.word[num] = 1'b1;
	endtask

	task automatic xclk_ticks(input int k);
		repeat (k) begin
			@(posedge iack);
			xclk_en_i <= 1'b1;
		end
		@(posedge iack);
		xclk_en_i <= 1'b0;
	endtask

	task automatic t0_rising_edges(input int k);
		repeat (k) begin
			@(posedge iack);
			t_i[0] <= 1'b1;
			@(posedge iack);
			t_i[0] <= 1'b0;
		end
	endtask

	initial begin
		logic [7:0] scratch;
		logic [7:0] n;
		irq_word_u  w;
		reset            <= 1'b1;
		sel_i            <= 1'b0;
		ds_i             <= 1'b1;
		rw_i             <= 1'b1;
		addr_i           <= 5'h00;
		din_i            <= 8'h00;
		int_ack_i        <= 1'b0;
		gpio_i           <= 8'h00;
		t_i              <= 2'b00;
		xclk_en_i        <= 1'b0;
		ser_out_strobe_i <= 1'b0;
		ser_in_data_i    <= 8'h00;
		ser_in_strobe_i  <= 1'b0;
		{sh_gpip, sh_aer, sh_ddr, sh_vr, sh_tadr, sh_tbdr} = '0;
		{sh_tacr, sh_tbcr, sh_tsr, sh_rsr} = '0;
		sh_ier = '0;
		sh_ipr = '0;
		sh_isr = '0;
		sh_imr = '0;
		repeat (2) @(posedge iack);
		reset <= 1'b0;

		// gpio read back, ddr picks pin or output latch per bit
		repeat (8) begin
			bus_write(ADDR_DDR, next_random());
			bus_write(ADDR_GPIP, next_random());
			bus_write(ADDR_AER, next_random());
			@(posedge iack);
			gpio_i <= next_random();
			bus_read(ADDR_GPIP, scratch);
			bus_read(ADDR_AER, scratch);
			bus_read(ADDR_DDR, scratch);
		end

		// gpio 7 rising edge, masked first, then acknowledged
		@(posedge iack);
		gpio_i <= 8'h00;
		bus_write(ADDR_DDR, 8'h00);
		bus_write(ADDR_AER, 8'h88);
		bus_write(ADDR_VR, 8'h48);
		bus_write(ADDR_IERA, 8'h80);
		drive_gpio(7, 1'b1);
		sh_ipr.word[IRQ_GPIO7] = 1'b1;
		w.word = 16'h8000;
		check_irq_reg("ipr", ADDR_IPRA, w);
		expect_irq(1'b0);
		bus_write(ADDR_IMRA, 8'h80);
		expect_irq(1'b1);
		int_acknowledge(4'd15);
		expect_irq(1'b0);
		w.word = 16'h0000;
		check_irq_reg("ipr", ADDR_IPRA, w);
		w.word = 16'h8000;
		check_irq_reg("isr", ADDR_ISRA, w);
		bus_write(ADDR_ISRA, 8'h7f);
		// wrong polarity and a disabled source leave ipr clear
		drive_gpio(7, 1'b0);
		drive_gpio(6, 1'b1);
		drive_gpio(6, 1'b0);
		w.word = 16'h0000;
		check_irq_reg("isr", ADDR_ISRA, w);
		check_irq_reg("ipr", ADDR_IPRA, w);

		// priority between gpio 7 and gpio 3
		bus_write(ADDR_IERB, 8'h08);
		bus_write(ADDR_IMRB, 8'h08);
		@(posedge iack);
		gpio_i[7] <= 1'b1;
		gpio_i[3] <= 1'b1;
		@(posedge iack);
		sh_ipr.word[IRQ_GPIO7] = 1'b1;
		sh_ipr.word[IRQ_GPIO_LO + 3] = 1'b1;
		expect_irq(1'b1);
		int_acknowledge(4'd15);
		// 3 is below the source in service
		expect_irq(1'b0);
		bus_write(ADDR_ISRA, 8'h00);
		expect_irq(1'b1);
		int_acknowledge(4'd3);
		expect_irq(1'b0);
		drive_gpio(7, 1'b0);
		drive_gpio(7, 1'b1);
		sh_ipr.word[IRQ_GPIO7] = 1'b1;
		// 15 preempts 3
		expect_irq(1'b1);
		int_acknowledge(4'd15);
		w.word = 16'h8008;
		check_irq_reg("isr", ADDR_ISRA, w);
		bus_write(ADDR_ISRA, 8'h00);
		bus_write(ADDR_ISRB, 8'h00);
		bus_write(ADDR_IERB, 8'h00);

		// timer a delay mode, code 1 steps every 4 ticks
		n = 8'd3 + (next_random() & 8'h07);
		bus_write(ADDR_IERA, 8'h20);
		bus_write(ADDR_TADR, n);
		bus_write(ADDR_TACR, 8'h01);
		xclk_ticks(4 * n - 1);
		repeat (2) @(posedge iack);
		bus_read(ADDR_IPRA, scratch);
		xclk_ticks(1);
		repeat (2) @(posedge iack);
		sh_ipr.word[IRQ_TIMER_A] = 1'b1;
		bus_read(ADDR_IPRA, scratch);
		bus_read(ADDR_TADR, scratch);

		// timer a event mode, aer bit 4 picks rising edges of t_i[0]
		bus_write(ADDR_TACR, 8'h00);
		bus_write(ADDR_IPRA, 8'h00);
		bus_write(ADDR_AER, 8'h10);
		bus_write(ADDR_TADR, n);
		bus_write(ADDR_TACR, {4'h0, TMODE_EVENT});
		t0_rising_edges(n - 1);
		repeat (2) @(posedge iack);
		bus_read(ADDR_IPRA, scratch);
		t0_rising_edges(1);
		repeat (2) @(posedge iack);
		sh_ipr.word[IRQ_TIMER_A] = 1'b1;
		bus_read(ADDR_IPRA, scratch);
		bus_read(ADDR_TADR, scratch);
		bus_write(ADDR_TACR, 8'h00);
		bus_write(ADDR_IERA, 8'h00);

		// transmit path, cpu fills, outside strobe drains in order
		bus_read(ADDR_TSR, scratch);
		repeat (FIFO_DEPTH) bus_write(ADDR_UDR, next_random());
		bus_read(ADDR_TSR, scratch);
		@(negedge iack);
		check_bit("ser_out_avail_o", 1'b1, ser_out_avail_o);
		while (tx_q.size() != 0) begin
			@(negedge iack);
			check_byte("ser_out_data_o", tx_q[0], ser_out_data_o);
			@(posedge iack);
			ser_out_strobe_i <= 1'b1;
			@(posedge iack);
			ser_out_strobe_i <= 1'b0;
			void'(tx_q.pop_front());
		end
		@(negedge iack);
		check_bit("ser_out_avail_o", 1'b0, ser_out_avail_o);
		bus_read(ADDR_TSR, scratch);

		// receive path, strobed bytes come back through udr
		bus_write(ADDR_IERA, 8'h10);
		repeat (FIFO_DEPTH) begin
			@(posedge iack);
			ser_in_data_i   <= next_random();
			ser_in_strobe_i <= 1'b1;
			@(posedge iack);
			ser_in_strobe_i <= 1'b0;
			rx_q.push_back(ser_in_data_i);
		end
		@(negedge iack);
		check_bit("ser_in_full_o", 1'b1, ser_in_full_o);
		sh_ipr.word[IRQ_RX_FULL] = 1'b1;
		bus_read(ADDR_RSR, scratch);
		bus_read(ADDR_IPRA, scratch);
		repeat (FIFO_DEPTH) bus_read(ADDR_UDR, scratch);
		bus_read(ADDR_RSR, scratch);
		@(negedge iack);
		check_bit("ser_in_full_o", 1'b0, ser_in_full_o);
		bus_write(ADDR_IERA, 8'h00);

		repeat (2) @(posedge iack);
		$display("test passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
mfp_pkg.sv
mfp_fifo.sv
mfp_timer.sv
mfp_irq_ctrl.sv
mfp_regs.sv
mfp_top.sv
tb_mfp.sv

//--- run.sh
#!/bin/sh
# build the mfp testbench with verilator, run it, and look for the pass line
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert --top-module tb_mfp -f flist.f \
	&& ./obj_dir/Vtb_mfp | tee /dev/stderr | grep -q "test passed" \
	|| { echo "mfp simulation did not pass" >&2; exit 1; }
